// File: logic/ring_geom_pkg.sv
// Ring geometry package holding depth, step limit and index widths
package ring_geom_pkg;

  // ------------------------------
  // Ring size and step limit
  // ------------------------------

  // Number of entries in the ring, which is also the wrap modulus of both indices
  localparam int RING_DEPTH = 12;

  // Largest number of entries a single push or pop may move an index by
  localparam int MAX_STEP = 3;

  // ------------------------------
  // Derived widths
  // ------------------------------

  // Enough bits to hold RING_DEPTH-1, the highest legal index
  localparam int INDEX_WIDTH = $clog2(RING_DEPTH);

  // Enough bits to hold MAX_STEP itself
  localparam int STEP_WIDTH = $clog2(MAX_STEP + 1);

  // Codes between RING_DEPTH and 2**INDEX_WIDTH-1 are never used by an index
  // This gap is removed again whenever a subtraction borrows past 0
  localparam int RING_MARGIN = (2 ** INDEX_WIDTH) - RING_DEPTH;

  typedef logic [INDEX_WIDTH-1:0] ring_index_t;
  typedef logic [STEP_WIDTH-1:0] ring_step_t;

endpackage : ring_geom_pkg

// File: logic/ring_status_pkg.sv
// Ring occupancy package holding the level width and the full threshold
package ring_status_pkg;

  import ring_geom_pkg::*;

  // ------------------------------
  // Occupancy encoding
  // ------------------------------

  // A level runs from 0 up to RING_DEPTH-1
  // It is the distance between two indices, so it never reaches RING_DEPTH itself
  localparam int LEVEL_WIDTH = $clog2(RING_DEPTH);

  // One slot always stays unused
  // Without that gap a full ring and an empty ring would have equal indices
  localparam int FULL_LEVEL = RING_DEPTH - 1;

  // ------------------------------
  // Types
  // ------------------------------

  // Occupancy count as seen by the level tracker and the top-level port
  typedef logic [LEVEL_WIDTH-1:0] ring_level_t;

  // Free space uses the same encoding because it is FULL_LEVEL minus a level
  // and so it also stays within 0 to FULL_LEVEL

endpackage : ring_status_pkg

// File: logic/ring_index_counter.sv
// Ring index counter that steps downward by a variable amount and wraps at a non-power-of-2 depth
`timescale 1ns/10ps

module ring_index_counter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     reinit,
  input  ring_geom_pkg::ring_index_t base_index,
  input  logic                     step_valid,
  input  ring_geom_pkg::ring_step_t  step,
  output ring_geom_pkg::ring_index_t index,
  output ring_geom_pkg::ring_index_t index_next
);

  import ring_geom_pkg::*;

  // ------------------------------
  // Next index computation
  // ------------------------------

  // Starting point of this cycle's update
  ring_index_t base;

  // Step widened to the index width, and the amount actually taken off
  ring_index_t step_ext;
  ring_index_t applied_step;

  // Plain binary difference before any wrap correction
  ring_index_t raw_next;

  // Difference with the unused codes above RING_DEPTH-1 removed
  ring_index_t wrapped_next;

  // High when the subtraction went below 0
  logic borrow;

  // A reinit replaces the current index as the starting point
  // A step in the same cycle is then taken from base_index and not lost
  assign base = reinit ? base_index : index;

  assign step_ext = INDEX_WIDTH'(step);

  // Without a strobe the step port carries no meaning and nothing is subtracted
  assign applied_step = step_valid ? step_ext : '0;

  assign raw_next = base - applied_step;

  // The binary result wraps to 2**INDEX_WIDTH, not to RING_DEPTH
  // So a borrow lands RING_MARGIN codes too high, in the range no index ever takes
  assign borrow = step_valid && (step_ext > base);

  // Taking the margin back off gives (base - step) mod RING_DEPTH
  // For a power-of-2 depth the margin is 0 and this path changes nothing
  assign wrapped_next = raw_next - INDEX_WIDTH'(RING_MARGIN);

  assign index_next = borrow ? wrapped_next : raw_next;

  // ------------------------------
  // Index register
  // ------------------------------

  // Reset loads the base index so both counters of a pair start level
  // The register only moves on a strobe or a reinit, index_next equals index otherwise
  always_ff @(posedge clk) begin
    if (reset) begin
      index <= base_index;
    end else if (step_valid || reinit) begin
      index <= index_next;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // The caller must never ask for more than the geometry allows
  step_in_range_a : assert property (
    @(posedge clk) disable iff (reset)
    step_valid |-> (step <= MAX_STEP)
  ) else $error("ring_index_counter: step %0d above MAX_STEP", step);

  // An out-of-range base would seed the ring with an unused code
  base_in_range_a : assert property (
    @(posedge clk) disable iff (reset)
    base_index < RING_DEPTH
  ) else $error("ring_index_counter: base_index %0d not below RING_DEPTH", base_index);

  // The wrap correction must keep the index out of the margin codes
  index_in_range_a : assert property (
    @(posedge clk) disable iff (reset)
    index < RING_DEPTH
  ) else $error("ring_index_counter: index %0d not below RING_DEPTH", index);

  // The combinational look-ahead must predict the register one cycle later
  // Downstream logic chained on index_next relies on this
  next_propagates_a : assert property (
    @(posedge clk) disable iff (reset)
    1'b1 |=> (index == $past(index_next))
  ) else $error("ring_index_counter: index does not match last index_next");

endmodule : ring_index_counter

// File: logic/ring_level_tracker.sv
// Ring level tracker giving fill level, empty and full flags, and sticky step errors
`timescale 1ns/10ps

module ring_level_tracker (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        reinit,
  input  ring_geom_pkg::ring_index_t    wr_index,
  input  ring_geom_pkg::ring_index_t    rd_index,
  input  logic                        push_valid,
  input  ring_geom_pkg::ring_step_t     push_step,
  input  logic                        pop_valid,
  input  ring_geom_pkg::ring_step_t     pop_step,
  output ring_status_pkg::ring_level_t level,
  output logic                        empty,
  output logic                        full,
  output logic                        overrun,
  output logic                        underrun
);

  import ring_geom_pkg::*;
  import ring_status_pkg::*;

  // ------------------------------
  // Level and flags
  // ------------------------------

  // Both indices move downward, so the writer sits below the reader
  // The entries in use are the distance from rd_index down to wr_index
  ring_index_t raw_diff;
  ring_index_t level_index;
  logic        diff_borrow;

  // Room left before the ring counts as full
  ring_level_t free_space;

  // Error conditions of this cycle before they reach the sticky registers
  logic overrun_set;
  logic underrun_set;

  assign raw_diff = rd_index - wr_index;

  // Same margin correction as in the counters when the subtraction borrows
  assign diff_borrow = wr_index > rd_index;
  assign level_index = diff_borrow ? (raw_diff - INDEX_WIDTH'(RING_MARGIN)) : raw_diff;

  assign level = LEVEL_WIDTH'(level_index);

  assign free_space = LEVEL_WIDTH'(FULL_LEVEL) - level;

  assign empty = (level == '0);
  assign full  = (free_space == '0);

  // ------------------------------
  // Sticky error flags
  // ------------------------------

  // Both conditions look at the level before this cycle's steps are applied
  // A reinit discards the old level, so nothing is judged against it
  assign overrun_set  = !reinit && push_valid && (LEVEL_WIDTH'(push_step) > free_space);
  assign underrun_set = !reinit && pop_valid && (LEVEL_WIDTH'(pop_step) > level);

  // The flags only record the mistake, the counters still take the steps
  // Once set they hold until reset or the next reinit
  always_ff @(posedge clk) begin
    if (reset || reinit) begin
      overrun  <= 1'b0;
      underrun <= 1'b0;
    end else begin
      if (overrun_set) begin
        overrun <= 1'b1;
      end
      if (underrun_set) begin
        underrun <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Holds only while both counters keep their indices inside the ring
  level_in_range_a : assert property (
    @(posedge clk) disable iff (reset)
    level <= FULL_LEVEL
  ) else $error("ring_level_tracker: level %0d above FULL_LEVEL", level);

endmodule : ring_level_tracker

// File: logic/ring_tracker_top.sv
// Ring tracker top joining the producer and consumer index counters with the level tracker
`timescale 1ns/10ps

module ring_tracker_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        reinit,
  input  ring_geom_pkg::ring_index_t    base_index,
  input  logic                        push_valid,
  input  ring_geom_pkg::ring_step_t     push_step,
  input  logic                        pop_valid,
  input  ring_geom_pkg::ring_step_t     pop_step,
  output ring_geom_pkg::ring_index_t    wr_index,
  output ring_geom_pkg::ring_index_t    rd_index,
  output ring_status_pkg::ring_level_t level,
  output logic                        empty,
  output logic                        full,
  output logic                        overrun,
  output logic                        underrun
);

  // ------------------------------
  // Index counters
  // ------------------------------

  // Producer side, moved down by every push
  // The look-ahead output has no user at this level
  ring_index_counter wr_counter (
    .clk        (clk),
    .reset      (reset),
    .reinit     (reinit),
    .base_index (base_index),
    .step_valid (push_valid),
    .step       (push_step),
    .index      (wr_index),
    .index_next ()
  );

  // Consumer side, moved down by every pop
  ring_index_counter rd_counter (
    .clk        (clk),
    .reset      (reset),
    .reinit     (reinit),
    .base_index (base_index),
    .step_valid (pop_valid),
    .step       (pop_step),
    .index      (rd_index),
    .index_next ()
  );

  // ------------------------------
  // Occupancy
  // ------------------------------

  // Works on the registered indices, so the level trails a strobe by one cycle
  // just as the indices do
  ring_level_tracker level_tracker (
    .clk        (clk),
    .reset      (reset),
    .reinit     (reinit),
    .wr_index   (wr_index),
    .rd_index   (rd_index),
    .push_valid (push_valid),
    .push_step  (push_step),
    .pop_valid  (pop_valid),
    .pop_step   (pop_step),
    .level      (level),
    .empty      (empty),
    .full       (full),
    .overrun    (overrun),
    .underrun   (underrun)
  );

endmodule : ring_tracker_top

// File: verif/ring_tracker_vectors.svh
// Directed stimulus rows for the ring tracker with the expected outputs after each clock edge
`ifndef RING_TRACKER_VECTORS_SVH
`define RING_TRACKER_VECTORS_SVH

// Inputs applied before the edge, then the outputs expected once the edge has passed
typedef struct packed {
  logic        reinit;
  ring_index_t base_index;
  logic        push_valid;
  ring_step_t  push_step;
  logic        pop_valid;
  ring_step_t  pop_step;
  ring_index_t exp_wr_index;
  ring_index_t exp_rd_index;
  ring_level_t exp_level;
  logic        exp_empty;
  logic        exp_full;
  logic        exp_overrun;
  logic        exp_underrun;
} vector_row_t;

localparam int NUM_ROWS = 22;

// Columns are reinit, base, push valid and step, pop valid and step,
// then wr_index, rd_index, level, empty, full, overrun, underrun
localparam vector_row_t VECTOR_TABLE [NUM_ROWS] = '{
  // Idle after reset, then single steps of 3 that wrap past 0
  '{1'b0, 4'd2, 1'b0, 2'd0, 1'b0, 2'd0, 4'd2, 4'd2, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b1, 2'd3, 1'b0, 2'd0, 4'd11, 4'd2, 4'd3, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b0, 2'd0, 1'b1, 2'd3, 4'd11, 4'd11, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0},
  // Fill up to FULL_LEVEL
  '{1'b0, 4'd2, 1'b1, 2'd3, 1'b0, 2'd0, 4'd8, 4'd11, 4'd3, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b1, 2'd3, 1'b0, 2'd0, 4'd5, 4'd11, 4'd6, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b1, 2'd3, 1'b0, 2'd0, 4'd2, 4'd11, 4'd9, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b1, 2'd2, 1'b0, 2'd0, 4'd0, 4'd11, 4'd11, 1'b0, 1'b1, 1'b0, 1'b0},
  // Drain back to empty, with simultaneous push and pop on the way
  '{1'b0, 4'd2, 1'b0, 2'd0, 1'b1, 2'd2, 4'd0, 4'd9, 4'd9, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b1, 2'd2, 1'b1, 2'd3, 4'd10, 4'd6, 4'd8, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b1, 2'd1, 1'b1, 2'd3, 4'd9, 4'd3, 4'd6, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b0, 2'd0, 1'b1, 2'd3, 4'd9, 4'd0, 4'd3, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd2, 1'b0, 2'd0, 1'b1, 2'd3, 4'd9, 4'd9, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0},
  // Underrun from empty, overrun from full, then legal cycles keep both flags
  '{1'b0, 4'd2, 1'b0, 2'd0, 1'b1, 2'd1, 4'd9, 4'd8, 4'd11, 1'b0, 1'b1, 1'b0, 1'b1},
  '{1'b0, 4'd2, 1'b1, 2'd1, 1'b0, 2'd0, 4'd8, 4'd8, 4'd0, 1'b1, 1'b0, 1'b1, 1'b1},
  '{1'b0, 4'd2, 1'b1, 2'd2, 1'b0, 2'd0, 4'd6, 4'd8, 4'd2, 1'b0, 1'b0, 1'b1, 1'b1},
  '{1'b0, 4'd2, 1'b0, 2'd0, 1'b1, 2'd2, 4'd6, 4'd6, 4'd0, 1'b1, 1'b0, 1'b1, 1'b1},
  // Reinit clears the flags, and steps in a reinit cycle start from the base
  '{1'b1, 4'd5, 1'b0, 2'd0, 1'b0, 2'd0, 4'd5, 4'd5, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0},
  '{1'b1, 4'd1, 1'b1, 2'd3, 1'b1, 2'd2, 4'd10, 4'd11, 4'd1, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b1, 4'd0, 1'b1, 2'd3, 1'b0, 2'd0, 4'd9, 4'd0, 4'd3, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b1, 4'd4, 1'b0, 2'd0, 1'b1, 2'd2, 4'd4, 4'd2, 4'd10, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd4, 1'b0, 2'd0, 1'b0, 2'd0, 4'd4, 4'd2, 4'd10, 1'b0, 1'b0, 1'b0, 1'b0},
  '{1'b0, 4'd4, 1'b0, 2'd0, 1'b1, 2'd2, 4'd4, 4'd0, 4'd8, 1'b0, 1'b0, 1'b0, 1'b0}
};

`endif

// File: verif/ring_tracker_tb.sv
// Testbench for the ring tracker running a directed table and a random phase against a model
`timescale 1ns/10ps

module ring_tracker_tb;

  import ring_geom_pkg::*;
  import ring_status_pkg::*;

  `include "ring_tracker_vectors.svh"

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 8;
  localparam int RANDOM_CYCLES = 200;
  localparam int MARGIN_CYCLES = 50;

  logic        clk;
  logic        reset;
  logic        reinit;
  ring_index_t base_index;
  logic        push_valid;
  ring_step_t  push_step;
  logic        pop_valid;
  ring_step_t  pop_step;
  ring_index_t wr_index;
  ring_index_t rd_index;
  ring_level_t level;
  logic        empty;
  logic        full;
  logic        overrun;
  logic        underrun;

  // Reference model state, kept as plain integers
  int   model_wr;
  int   model_rd;
  logic model_overrun;
  logic model_underrun;

  int error_count;
  int tests_run;
  int tests_failed;

  ring_tracker_top dut (
    .clk        (clk),
    .reset      (reset),
    .reinit     (reinit),
    .base_index (base_index),
    .push_valid (push_valid),
    .push_step  (push_step),
    .pop_valid  (pop_valid),
    .pop_step   (pop_step),
    .wr_index   (wr_index),
    .rd_index   (rd_index),
    .level      (level),
    .empty      (empty),
    .full       (full),
    .overrun    (overrun),
    .underrun   (underrun)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // Reference model
  // ------------------------------

  // Indices move downward and wrap modulo the ring depth
  function automatic int step_down(input int base, input logic valid, input int step);
    if (valid) begin
      return (base - step + RING_DEPTH) % RING_DEPTH;
    end
    return base;
  endfunction

  // Entries in use are the distance from the read index down to the write index
  function automatic int level_of(input int wr, input int rd);
    return (rd - wr + RING_DEPTH) % RING_DEPTH;
  endfunction

  // Called once the inputs for the coming edge are on the pins
  task automatic advance_model();
    int lvl;
    int base_wr;
    int base_rd;
    lvl = level_of(model_wr, model_rd);
    base_wr = reinit ? int'(base_index) : model_wr;
    base_rd = reinit ? int'(base_index) : model_rd;
    if (reinit) begin
      model_overrun  = 1'b0;
      model_underrun = 1'b0;
    end else begin
      // Errors are judged against the level before the steps land
      if (push_valid && int'(push_step) > FULL_LEVEL - lvl) begin
        model_overrun = 1'b1;
      end
      if (pop_valid && int'(pop_step) > lvl) begin
        model_underrun = 1'b1;
      end
    end
    model_wr = step_down(base_wr, push_valid, int'(push_step));
    model_rd = step_down(base_rd, pop_valid, int'(pop_step));
  endtask

  // ------------------------------
  // Stimulus and checks
  // ------------------------------

  task automatic drive_inputs(input logic r, input ring_index_t b, input logic pv,
                              input ring_step_t ps, input logic qv, input ring_step_t qs);
    reinit     = r;
    base_index = b;
    push_valid = pv;
    push_step  = ps;
    pop_valid  = qv;
    pop_step   = qs;
  endtask

  task automatic compare_outputs(input ring_index_t exp_wr, input ring_index_t exp_rd,
                                 input ring_level_t exp_level, input logic exp_empty,
                                 input logic exp_full, input logic exp_overrun,
                                 input logic exp_underrun, output int mismatches);
    mismatches = 0;
    if (wr_index !== exp_wr) begin
      $display("ERROR wr_index expected 0x%h got 0x%h", exp_wr, wr_index);
      mismatches++;
    end
    if (rd_index !== exp_rd) begin
      $display("ERROR rd_index expected 0x%h got 0x%h", exp_rd, rd_index);
      mismatches++;
    end
    if (level !== exp_level) begin
      $display("ERROR level expected 0x%h got 0x%h", exp_level, level);
      mismatches++;
    end
    if (empty !== exp_empty) begin
      $display("ERROR empty expected 0x%h got 0x%h", exp_empty, empty);
      mismatches++;
    end
    if (full !== exp_full) begin
      $display("ERROR full expected 0x%h got 0x%h", exp_full, full);
      mismatches++;
    end
    if (overrun !== exp_overrun) begin
      $display("ERROR overrun expected 0x%h got 0x%h", exp_overrun, overrun);
      mismatches++;
    end
    if (underrun !== exp_underrun) begin
      $display("ERROR underrun expected 0x%h got 0x%h", exp_underrun, underrun);
      mismatches++;
    end
    error_count += mismatches;
  endtask

  task automatic report_test(input string name, input int mismatches);
    tests_run++;
    if (mismatches != 0) begin
      tests_failed++;
      $display("test %s failed with %0d mismatches", name, mismatches);
    end else begin
      $display("test %s passed", name);
    end
  endtask

  initial begin
    int mismatches;
    int random_total;
    int lvl;
    vector_row_t row;
    void'($urandom(87));
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset = 1'b1;
    drive_inputs(1'b0, 4'd2, 1'b0, 2'd0, 1'b0, 2'd0);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    model_wr       = int'(base_index);
    model_rd       = int'(base_index);
    model_overrun  = 1'b0;
    model_underrun = 1'b0;

    // Both indices sit at the reset base and the ring is empty
    compare_outputs(4'd2, 4'd2, '0, 1'b1, 1'b0, 1'b0, 1'b0, mismatches);
    report_test("after reset", mismatches);

    for (int i = 0; i < NUM_ROWS; i++) begin
      row = VECTOR_TABLE[i];
      drive_inputs(row.reinit, row.base_index, row.push_valid, row.push_step,
                   row.pop_valid, row.pop_step);
      advance_model();
      @(posedge clk);
      @(negedge clk);
      compare_outputs(row.exp_wr_index, row.exp_rd_index, row.exp_level, row.exp_empty,
                      row.exp_full, row.exp_overrun, row.exp_underrun, mismatches);
      report_test($sformatf("row %0d", i), mismatches);
    end

    // Random phase, with a reinit roughly once every 16 cycles
    random_total = 0;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      drive_inputs(($urandom % 16) == 0, ring_index_t'($urandom % RING_DEPTH),
                   1'($urandom % 2), ring_step_t'($urandom % (MAX_STEP + 1)),
                   1'($urandom % 2), ring_step_t'($urandom % (MAX_STEP + 1)));
      advance_model();
      @(posedge clk);
      @(negedge clk);
      lvl = level_of(model_wr, model_rd);
      compare_outputs(ring_index_t'(model_wr), ring_index_t'(model_rd), ring_level_t'(lvl),
                      lvl == 0, lvl == FULL_LEVEL, model_overrun, model_underrun,
                      mismatches);
      random_total += mismatches;
    end
    report_test("random phase", random_total);

    $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the reset, the table and the random phase
  initial begin
    #((RESET_CYCLES + NUM_ROWS + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("timeout: the run did not reach its end in the expected time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : ring_tracker_tb

// File: flist.f
+incdir+verif
logic/ring_geom_pkg.sv
logic/ring_status_pkg.sv
logic/ring_index_counter.sv
logic/ring_level_tracker.sv
logic/ring_tracker_top.sv
verif/ring_tracker_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the ring tracker testbench with Verilator, run it and check the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ring_tracker_tb \
  -f flist.f -o ring_tracker_sim \
  && ./obj_dir/ring_tracker_sim 2>&1 | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -qx "NO ERRORS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
